// ==== chain_cmd_pkg.sv ====
package chain_cmd_pkg;

	// command opcodes
	// codes 2 and 3 are unused and behave as pass
	typedef enum logic [1:0] {
		OP_PASS = 2'd0,
		OP_SUBS = 2'd1
	} opcode_e;

	// which half of the head command is presented
	typedef enum logic {
		HEAD_POLY_A = 1'b0,
		HEAD_POLY_B = 1'b1
	} rob_state_e;

	// execute sequencer
	typedef enum logic [1:0] {
		EX_IDLE  = 2'd0,
		EX_READ  = 2'd1,
		EX_DRAIN = 2'd2
	} exec_state_e;

endpackage

// ==== chain_defs.svh ====
`ifndef CHAIN_DEFS_SVH
`define CHAIN_DEFS_SVH

//////////////////////////////
// ring dimensions
//////////////////////////////

// coefficients per polynomial
`define CHAIN_N         16

// prime modulus q
`define CHAIN_Q         12289

// coefficient width, holds values below q
`define CHAIN_COEF_W    14

// coefficient index width, log2 of N
`define CHAIN_ADDR_W    4

//////////////////////////////
// routing and queue
//////////////////////////////

// iNTT lanes, each with a poly a and a poly b buffer
`define CHAIN_LANES     4

// command queue entries
`define CHAIN_ROB_DEPTH 8

// substitution factor width, k = 2*factor+1
`define CHAIN_SUBS_W    4

`endif

// ==== chain_types_pkg.sv ====
`include "chain_defs.svh"

package chain_types_pkg;

	// one coefficient mod q
	typedef logic [`CHAIN_COEF_W-1:0] coef_t;

	// coefficient index inside a polynomial
	typedef logic [`CHAIN_ADDR_W-1:0] addr_t;

	// iNTT lane id
	typedef logic [$clog2(`CHAIN_LANES)-1:0] lane_t;

	// poly id, 0 is poly a, 1 is poly b
	typedef logic poly_t;

	// automorphism factor before the 2x+1 mapping
	typedef logic [`CHAIN_SUBS_W-1:0] subs_t;

endpackage

// ==== cmd_rob.sv ====
`timescale 1ns/1ps
`include "chain_defs.svh"

module cmd_rob
	import chain_types_pkg::*;
	import chain_cmd_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    wr_en,
	input  opcode_e opcode_in,
	input  lane_t   lane_in,
	input  subs_t   subs_in,
	input  logic    job_done,
	output logic    full,
	output logic    empty,
	output logic    head_valid,
	output opcode_e head_opcode,
	output lane_t   head_lane,
	output poly_t   head_poly,
	output subs_t   head_subs
);

	localparam int DEPTH = `CHAIN_ROB_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	// entry storage without the poly id
	opcode_e mem_opcode [DEPTH];
	lane_t   mem_lane   [DEPTH];
	subs_t   mem_subs   [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	rob_state_e       head_state;

	logic push;
	logic pop;

	//////////////////////////////
	// push / pop
	//////////////////////////////

	// writes while full are dropped
	assign push = wr_en && !full;
	// entry retires only after poly b is done
	assign pop  = job_done && (head_state == HEAD_POLY_B);

	assign full       = (count == (PTR_W+1)'(DEPTH));
	assign empty      = (count == '0);
	assign head_valid = !empty;

	// payload write
	always_ff @(posedge clk) begin
		if (push) begin
			mem_opcode[wr_ptr] <= opcode_in;
			mem_lane[wr_ptr]   <= lane_in;
			mem_subs[wr_ptr]   <= subs_in;
		end
	end

	// pointers wrap at the power of two depth
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	//////////////////////////////
	// head phase
	//////////////////////////////

	// every job_done flips between poly a and poly b
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			head_state <= HEAD_POLY_A;
		else if (job_done)
			head_state <= (head_state == HEAD_POLY_A) ? HEAD_POLY_B : HEAD_POLY_A;
	end

	assign head_opcode = mem_opcode[rd_ptr];
	assign head_lane   = mem_lane[rd_ptr];
	assign head_subs   = mem_subs[rd_ptr];
	assign head_poly   = poly_t'(head_state == HEAD_POLY_B);

	// upstream must hold off while the queue is full
	a_no_write_when_full : assert property (
		@(posedge clk) disable iff (!rst_n) wr_en |-> !full
	) else $error("cmd_rob: write attempted while full");

endmodule

// ==== compute_chain_top.sv ====
`timescale 1ns/1ps
`include "chain_defs.svh"

module compute_chain_top
	import chain_types_pkg::*;
	import chain_cmd_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	// command side
	input  logic    rob_wr_en,
	input  opcode_e opcode_in,
	input  lane_t   intt_id_in,
	input  subs_t   subs_factor_in,
	output logic    rob_full,
	output logic    rob_empty,
	// iNTT output buffers, lane*2 + poly
	input  logic    lane_empty     [`CHAIN_LANES*2],
	input  coef_t   lane_dout      [`CHAIN_LANES*2],
	output logic    lane_rd_en     [`CHAIN_LANES*2],
	output logic    lane_rd_finish [`CHAIN_LANES*2],
	output addr_t   lane_addr,
	// result write stream
	output logic    out_valid,
	output addr_t   out_addr,
	output coef_t   out_data,
	output poly_t   out_poly,
	output logic    job_done
);

	// queue head
	logic    head_valid;
	opcode_e head_opcode;
	lane_t   head_lane;
	poly_t   head_poly;
	subs_t   head_subs;

	// selected buffer
	logic  sel_empty;
	coef_t sel_dout;
	logic  rd_en;
	logic  rd_finish;
	addr_t rd_addr;

	// execute to result
	logic  exec_valid;
	logic  exec_last;
	addr_t exec_addr;
	coef_t exec_data;

	cmd_rob i_cmd_rob (
		.clk(clk), .rst_n(rst_n),
		.wr_en(rob_wr_en), .opcode_in(opcode_in), .lane_in(intt_id_in),
		.subs_in(subs_factor_in), .job_done(job_done),
		.full(rob_full), .empty(rob_empty), .head_valid(head_valid),
		.head_opcode(head_opcode), .head_lane(head_lane),
		.head_poly(head_poly), .head_subs(head_subs)
	);

	lane_router i_lane_router (
		.head_valid(head_valid), .head_lane(head_lane), .head_poly(head_poly),
		.rd_en(rd_en), .rd_finish(rd_finish), .addr(rd_addr),
		.lane_empty(lane_empty), .lane_dout(lane_dout),
		.lane_rd_en(lane_rd_en), .lane_rd_finish(lane_rd_finish),
		.lane_addr(lane_addr), .sel_empty(sel_empty), .sel_dout(sel_dout)
	);

	subs_unit i_subs_unit (
		.clk(clk), .rst_n(rst_n),
		.head_valid(head_valid), .head_opcode(head_opcode), .head_subs(head_subs),
		.job_done(job_done), .sel_empty(sel_empty), .sel_dout(sel_dout),
		.rd_en(rd_en), .rd_finish(rd_finish), .addr(rd_addr),
		.exec_valid(exec_valid), .exec_last(exec_last),
		.exec_addr(exec_addr), .exec_data(exec_data)
	);

	result_stage i_result_stage (
		.clk(clk), .rst_n(rst_n),
		.exec_valid(exec_valid), .exec_last(exec_last),
		.exec_addr(exec_addr), .exec_data(exec_data), .head_poly(head_poly),
		.out_valid(out_valid), .out_addr(out_addr), .out_data(out_data),
		.out_poly(out_poly), .job_done(job_done)
	);

endmodule

// ==== files.f ====
+incdir+.
chain_types_pkg.sv
chain_cmd_pkg.sv
cmd_rob.sv
lane_router.sv
subs_unit.sv
result_stage.sv
compute_chain_top.sv
tb_compute_chain.sv

// ==== lane_router.sv ====
`timescale 1ns/1ps
`include "chain_defs.svh"

module lane_router
	import chain_types_pkg::*;
(
	input  logic  head_valid,
	input  lane_t head_lane,
	input  poly_t head_poly,
	input  logic  rd_en,
	input  logic  rd_finish,
	input  addr_t addr,
	input  logic  lane_empty     [`CHAIN_LANES*2],
	input  coef_t lane_dout      [`CHAIN_LANES*2],
	output logic  lane_rd_en     [`CHAIN_LANES*2],
	output logic  lane_rd_finish [`CHAIN_LANES*2],
	output addr_t lane_addr,
	output logic  sel_empty,
	output coef_t sel_dout
);

	localparam int BUFS  = `CHAIN_LANES * 2;
	localparam int SEL_W = $clog2(BUFS);

	// buffer index is lane*2 + poly
	logic [SEL_W-1:0] sel_idx;
	logic [BUFS-1:0]  sel_oh;

	assign sel_idx = {head_lane, head_poly};

	//////////////////////////////
	// inward mux
	//////////////////////////////

	// nothing selected reads as not ready
	assign sel_empty = head_valid ? lane_empty[sel_idx] : 1'b1;
	assign sel_dout  = lane_dout[sel_idx];

	//////////////////////////////
	// outward steering
	//////////////////////////////

	// address is shared
	// buffers only act on their own rd_en
	assign lane_addr = addr;

	always_comb begin
		sel_oh = '0;
		if (head_valid)
			sel_oh[sel_idx] = 1'b1;
		for (int i = 0; i < BUFS; i++) begin
			lane_rd_en[i]     = sel_oh[i] & rd_en;
			lane_rd_finish[i] = sel_oh[i] & rd_finish;
		end
	end

	// the reader only runs while a job sits at the head
	always_comb begin
		a_rd_selected : assert final (head_valid || !(rd_en || rd_finish))
			else $error("lane_router: read control with no buffer selected");
	end

endmodule

// ==== result_stage.sv ====
`timescale 1ns/1ps
`include "chain_defs.svh"

module result_stage
	import chain_types_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  exec_valid,
	input  logic  exec_last,
	input  addr_t exec_addr,
	input  coef_t exec_data,
	input  poly_t head_poly,
	output logic  out_valid,
	output addr_t out_addr,
	output coef_t out_data,
	output poly_t out_poly,
	output logic  job_done
);

	// writes already done in the current job
	logic [`CHAIN_ADDR_W:0] wr_cnt;

	//////////////////////////////
	// output write register
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			job_done  <= 1'b0;
		end else begin
			out_valid <= exec_valid;
			// done rides along with the final write
			job_done  <= exec_valid && exec_last;
		end
	end

	// head still points at this job while its data is in flight
	always_ff @(posedge clk) begin
		if (exec_valid) begin
			out_addr <= exec_addr;
			out_data <= exec_data;
			out_poly <= head_poly;
		end
	end

	// per job write count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wr_cnt <= '0;
		else if (job_done)
			wr_cnt <= '0;
		else if (out_valid)
			wr_cnt <= wr_cnt + 1'b1;
	end

	// last flag from the sequencer agrees with the write count
	a_done_at_n : assert property (
		@(posedge clk) disable iff (!rst_n)
		job_done |-> ((wr_cnt + 1'b1) == (`CHAIN_ADDR_W+1)'(`CHAIN_N))
	) else $error("result_stage: job_done without N writes");

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the compute chain testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module tb_compute_chain -o sim_compute_chain

./obj_dir/sim_compute_chain > sim.log 2>&1 || true
cat sim.log

if grep -q "^Regression passed$" sim.log; then
	exit 0
fi
exit 1

// ==== subs_unit.sv ====
`timescale 1ns/1ps
`include "chain_defs.svh"

module subs_unit
	import chain_types_pkg::*;
	import chain_cmd_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    head_valid,
	input  opcode_e head_opcode,
	input  subs_t   head_subs,
	input  logic    job_done,
	input  logic    sel_empty,
	input  coef_t   sel_dout,
	output logic    rd_en,
	output logic    rd_finish,
	output addr_t   addr,
	output logic    exec_valid,
	output logic    exec_last,
	output addr_t   exec_addr,
	output coef_t   exec_data
);

	localparam int    MULT_W = `CHAIN_SUBS_W + 1;
	localparam int    PROD_W = `CHAIN_ADDR_W + MULT_W;
	localparam addr_t LAST   = addr_t'(`CHAIN_N - 1);
	localparam coef_t Q      = coef_t'(`CHAIN_Q);

	exec_state_e       state;
	addr_t             rd_cnt;
	logic [MULT_W-1:0] mult_q;

	// stage 1 is the memory data cycle
	logic    v_d1;
	logic    last_d1;
	addr_t   idx_d1;
	opcode_e op_d1;

	logic [PROD_W-1:0] prod;
	addr_t             dest;
	logic              wrap;
	logic              do_subs;
	coef_t             neg_data;

	//////////////////////////////
	// read sequencer
	//////////////////////////////

	// one read per clock unless the buffer is empty
	assign rd_en     = (state == EX_READ) && !sel_empty;
	assign rd_finish = rd_en && (rd_cnt == LAST);
	assign addr      = rd_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= EX_IDLE;
			rd_cnt <= '0;
			mult_q <= MULT_W'(1);
		end else begin
			case (state)
				EX_IDLE: begin
					if (head_valid) begin
						state  <= EX_READ;
						rd_cnt <= '0;
						// k = 2*factor + 1
						mult_q <= {head_subs, 1'b1};
					end
				end
				EX_READ: begin
					if (rd_en) begin
						rd_cnt <= rd_cnt + 1'b1;
						if (rd_cnt == LAST)
							state <= EX_DRAIN;
					end
				end
				// hold until the result stage retires the job
				EX_DRAIN: begin
					if (job_done)
						state <= EX_IDLE;
				end
				default: state <= EX_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// index / opcode delay
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v_d1    <= 1'b0;
			last_d1 <= 1'b0;
		end else begin
			v_d1    <= rd_en;
			last_d1 <= rd_finish;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			idx_d1 <= rd_cnt;
			op_d1  <= head_opcode;
		end
	end

	//////////////////////////////
	// substitution datapath
	//////////////////////////////

	// low bits of j*k give the index
	// the next bit up gives the sign
	assign prod     = idx_d1 * mult_q;
	assign wrap     = prod[`CHAIN_ADDR_W];
	assign do_subs  = (op_d1 == OP_SUBS);
	assign dest     = do_subs ? prod[`CHAIN_ADDR_W-1:0] : idx_d1;
	// -v mod q with zero kept as zero
	assign neg_data = (sel_dout == '0) ? '0 : Q - sel_dout;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exec_valid <= 1'b0;
			exec_last  <= 1'b0;
		end else begin
			exec_valid <= v_d1;
			exec_last  <= v_d1 && last_d1;
		end
	end

	always_ff @(posedge clk) begin
		if (v_d1) begin
			exec_addr <= dest;
			exec_data <= (do_subs && wrap) ? neg_data : sel_dout;
		end
	end

	// the result stage retires a job only after its last read
	a_done_in_drain : assert property (
		@(posedge clk) disable iff (!rst_n) job_done |-> (state == EX_DRAIN)
	) else $error("subs_unit: job_done before the last read");

endmodule

// ==== tb_compute_chain.sv ====
`timescale 1ns/1ps
`include "chain_defs.svh"

module tb_compute_chain
	import chain_types_pkg::*;
	import chain_cmd_pkg::*;
();

	localparam int N    = `CHAIN_N;
	localparam int Q    = `CHAIN_Q;
	localparam int BUFS = `CHAIN_LANES * 2;

	logic    clk;
	logic    rst_n;
	logic    rob_wr_en;
	opcode_e opcode_in;
	lane_t   intt_id_in;
	subs_t   subs_factor_in;
	logic    rob_full;
	logic    rob_empty;
	logic    lane_empty     [BUFS];
	coef_t   lane_dout      [BUFS];
	logic    lane_rd_en     [BUFS];
	logic    lane_rd_finish [BUFS];
	addr_t   lane_addr;
	logic    out_valid;
	addr_t   out_addr;
	coef_t   out_data;
	poly_t   out_poly;
	logic    job_done;

	// lane buffer contents and read data register
	coef_t buf_mem [BUFS][N];
	coef_t dout_q  [BUFS];

	// queue model with one entry per command
	opcode_e mq_op   [$];
	lane_t   mq_lane [$];
	subs_t   mq_subs [$];
	poly_t   cur_poly;
	logic    seen    [N];
	coef_t   got     [N];
	coef_t   exp_val [N];

	logic [31:0] rng;
	logic        hold_empty;
	int          errors;
	int          timeouts;
	int          jobs_done;

	compute_chain_top i_compute_chain_top (
		.clk(clk), .rst_n(rst_n),
		.rob_wr_en(rob_wr_en), .opcode_in(opcode_in), .intt_id_in(intt_id_in),
		.subs_factor_in(subs_factor_in), .rob_full(rob_full), .rob_empty(rob_empty),
		.lane_empty(lane_empty), .lane_dout(lane_dout),
		.lane_rd_en(lane_rd_en), .lane_rd_finish(lane_rd_finish), .lane_addr(lane_addr),
		.out_valid(out_valid), .out_addr(out_addr), .out_data(out_data),
		.out_poly(out_poly), .job_done(job_done)
	);

	always #20 clk = ~clk;

	//////////////////////////////
	// random source
	//////////////////////////////

	function automatic logic [31:0] rand_word();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	// fresh coefficients below q
	task automatic refill_buffer(input int b);
		for (int j = 0; j < N; j++)
			buf_mem[b][j] = coef_t'(rand_word() % Q);
	endtask

	//////////////////////////////
	// lane buffers
	//////////////////////////////

	// data comes back one cycle after the read
	// routing is checked on the same edge
	always @(posedge clk) begin
		int cur_buf;
		if (!rst_n) begin
			for (int b = 0; b < BUFS; b++)
				dout_q[b] <= '0;
		end else begin
			cur_buf = (mq_op.size() != 0) ? int'(mq_lane[0]) * 2 + int'(cur_poly) : -1;
			for (int b = 0; b < BUFS; b++) begin
				if (lane_rd_en[b])
					dout_q[b] <= buf_mem[b][lane_addr];
				assert (!(lane_rd_en[b] || lane_rd_finish[b]) || b == cur_buf) else begin
					$display("FAILED at %0t: read control on buffer %0d, current buffer %0d",
						$time, b, cur_buf);
					errors++;
				end
				assert (lane_rd_finish[b] == (lane_rd_en[b] && lane_addr == addr_t'(N-1)))
				else begin
					$display("FAILED at %0t: buffer %0d rd_finish %0d does not match the last read",
						$time, b, lane_rd_finish[b]);
					errors++;
				end
			end
		end
	end

	task automatic drive_lanes();
		for (int b = 0; b < BUFS; b++) begin
			lane_dout[b]  = dout_q[b];
			// roughly one cycle in four not ready
			lane_empty[b] = hold_empty ? 1'b1 : (rand_word() % 4 == 0);
		end
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////

	// X -> X^k with k = 2f+1
	// sign flips when j*k mod 2N lands in the upper half
	task automatic build_expected(input int b, input opcode_e op, input subs_t f);
		int k;
		int p;
		coef_t v;
		k = 2 * int'(f) + 1;
		for (int j = 0; j < N; j++) begin
			p = (j * k) % (2 * N);
			v = buf_mem[b][j];
			if (op != OP_SUBS)
				exp_val[j] = v;
			else if (p >= N)
				exp_val[p % N] = (v == 0) ? coef_t'(0) : coef_t'(Q - int'(v));
			else
				exp_val[p % N] = v;
		end
	endtask

	task automatic check_outputs();
		int b;
		if (out_valid) begin
			assert (mq_op.size() != 0 && out_poly == cur_poly) else begin
				$display("FAILED at %0t: write with poly %0d, no matching job pending",
					$time, out_poly);
				errors++;
			end
			assert (!seen[out_addr]) else begin
				$display("FAILED at %0t: address %0d written twice in one job", $time, out_addr);
				errors++;
			end
			seen[out_addr] = 1'b1;
			got[out_addr]  = out_data;
		end
		if (job_done) begin
			assert (out_valid && mq_op.size() != 0) else begin
				$display("FAILED at %0t: job_done without a final write", $time);
				errors++;
			end
		end
		if (job_done && mq_op.size() != 0) begin
			b = int'(mq_lane[0]) * 2 + int'(cur_poly);
			build_expected(b, mq_op[0], mq_subs[0]);
			for (int j = 0; j < N; j++) begin
				assert (seen[j] && got[j] == exp_val[j]) else begin
					$display("FAILED at %0t: job %0d addr %0d got %0d expected %0d written %0d",
						$time, jobs_done, j, got[j], exp_val[j], seen[j]);
					errors++;
				end
				seen[j] = 1'b0;
			end
			// the buffer produces a new poly once consumed
			refill_buffer(b);
			jobs_done++;
			if (cur_poly == 1'b0) begin
				cur_poly = 1'b1;
			end else begin
				cur_poly = 1'b0;
				void'(mq_op.pop_front());
				void'(mq_lane.pop_front());
				void'(mq_subs.pop_front());
			end
		end
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////

	task automatic tick();
		@(negedge clk);
		check_outputs();
		drive_lanes();
	endtask

	task automatic send_cmd(input opcode_e op, input lane_t lane, input subs_t f);
		int cycles;
		cycles = 0;
		while (rob_full && cycles < 2000) begin
			tick();
			cycles++;
		end
		assert (!rob_full) else begin
			$display("timed out waiting for a free queue entry at %0t", $time);
			timeouts++;
		end
		if (!rob_full) begin
			rob_wr_en      = 1'b1;
			opcode_in      = op;
			intt_id_in     = lane;
			subs_factor_in = f;
			mq_op.push_back(op);
			mq_lane.push_back(lane);
			mq_subs.push_back(f);
			tick();
			rob_wr_en = 1'b0;
		end
	endtask

	// mode 0 pass, 1 subs, 2 any code, 3 any code back to back
	task automatic run_cmds(input int count, input int mode);
		opcode_e op;
		lane_t   lane;
		subs_t   f;
		for (int i = 0; i < count; i++) begin
			op   = (mode == 0) ? OP_PASS : (mode == 1) ? OP_SUBS : opcode_e'(2'(rand_word()));
			lane = lane_t'(rand_word());
			f    = subs_t'(rand_word());
			send_cmd(op, lane, f);
			if (timeouts != 0)
				return;
			if (mode != 3)
				repeat (int'(rand_word() % 3)) tick();
		end
	endtask

	task automatic wait_drain(input int limit);
		int cycles;
		cycles = 0;
		while ((!rob_empty || mq_op.size() != 0) && cycles < limit) begin
			tick();
			cycles++;
		end
		assert (rob_empty && mq_op.size() == 0) else begin
			$display("timed out waiting for the queue to drain at %0t", $time);
			timeouts++;
		end
	endtask

	task automatic check_reset_state();
		assert (rob_empty && !rob_full && !out_valid && !job_done) else begin
			$display("FAILED at %0t: reset state empty %0d full %0d valid %0d done %0d",
				$time, rob_empty, rob_full, out_valid, job_done);
			errors++;
		end
		for (int b = 0; b < BUFS; b++) begin
			assert (!lane_rd_en[b] && !lane_rd_finish[b]) else begin
				$display("FAILED at %0t: buffer %0d read active after reset", $time, b);
				errors++;
			end
		end
	endtask

	initial begin
		clk            = 1'b0;
		rst_n          = 1'b0;
		rob_wr_en      = 1'b0;
		opcode_in      = OP_PASS;
		intt_id_in     = '0;
		subs_factor_in = '0;
		hold_empty     = 1'b1;
		rng            = 32'h8fb89f23;
		cur_poly       = 1'b0;
		errors         = 0;
		timeouts       = 0;
		jobs_done      = 0;
		for (int b = 0; b < BUFS; b++) begin
			lane_empty[b] = 1'b1;
			lane_dout[b]  = '0;
			refill_buffer(b);
		end
		for (int j = 0; j < N; j++)
			seen[j] = 1'b0;

		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		tick();
		check_reset_state();

		// pass then substitution then mixed codes under random stalls
		hold_empty = 1'b0;
		run_cmds(6, 0);
		if (timeouts == 0)
			wait_drain(4000);
		if (timeouts == 0)
			run_cmds(10, 1);
		if (timeouts == 0)
			wait_drain(6000);
		if (timeouts == 0)
			run_cmds(12, 2);
		if (timeouts == 0)
			wait_drain(6000);

		// fill the queue with every lane stalled
		if (timeouts == 0) begin
			hold_empty = 1'b1;
			tick();
			run_cmds(8, 3);
			assert (rob_full && !rob_empty) else begin
				$display("FAILED at %0t: full %0d empty %0d after eight writes",
					$time, rob_full, rob_empty);
				errors++;
			end
			// ninth command withheld while full
			// nothing may move while every lane is stalled
			repeat (10) begin
				tick();
				assert (rob_full && !out_valid) else begin
					$display("FAILED at %0t: full %0d valid %0d while stalled",
						$time, rob_full, out_valid);
					errors++;
				end
			end
			hold_empty = 1'b0;
			wait_drain(8000);
		end

		$display("errors %0d, timeouts %0d, jobs checked %0d", errors, timeouts, jobs_done);
		if (errors == 0 && timeouts == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
